//--- dcache_array_if.sv
// joins the controller to the tag and data arrays; the controller alone decides when to write
`timescale 1ns/100ps

interface dcache_array_if;

    // from the held request
    logic [dcache_pkg::index_bits-1:0] index;
    logic [dcache_pkg::tag_bits-1:0]   req_tag;
    logic [dcache_pkg::word_bits-1:0]  word;
    logic [dcache_pkg::way_bits-1:0]   victim_way;

    // store hit
    logic        store_en;
    logic [3:0]  wstrb;
    logic [31:0] wdata;

    // refill beats from memory
    logic                              refill_en;
    logic [dcache_pkg::way_bits-1:0]   refill_way;
    logic [dcache_pkg::index_bits-1:0] refill_index;
    logic [dcache_pkg::tag_bits-1:0]   refill_tag;
    logic [dcache_pkg::word_bits-1:0]  refill_word;
    logic [31:0]                       refill_data;
    logic                              refill_last;

    // lookup results
    logic                               hit;
    logic [dcache_pkg::way_bits-1:0]    hit_way;
    logic                               victim_valid;
    logic                               victim_dirty;
    logic [dcache_pkg::tag_bits-1:0]    victim_tag;
    logic [31:0]                        rdata_word;
    logic [dcache_pkg::line_bits-1:0]   victim_line;

    modport ctrl (
        output index, req_tag, word, victim_way, store_en, wstrb, wdata,
        output refill_en, refill_way, refill_index, refill_tag, refill_word,
        output refill_data, refill_last,
        input  hit, hit_way, victim_valid, victim_dirty, victim_tag, rdata_word, victim_line
    );

    modport tags (
        input  index, req_tag, victim_way, store_en,
        input  refill_en, refill_way, refill_index, refill_tag, refill_last,
        output hit, hit_way, victim_valid, victim_dirty, victim_tag
    );

    modport data (
        input  index, word, hit_way, victim_way, store_en, wstrb, wdata,
        input  refill_en, refill_way, refill_index, refill_word, refill_data,
        output rdata_word, victim_line
    );

endinterface

//--- dcache_ctrl.sv
// one request in flight; memory returns a line in order from word 0 and ret_* is always accepted
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               req_valid,
    input  logic                               req_op,
    input  dcache_pkg::addr_t                  req_addr,
    input  logic [3:0]                         req_wstrb,
    input  logic [31:0]                        req_wdata,
    output logic                               req_ready,
    output logic                               resp_valid,
    output logic [31:0]                        resp_rdata,
    output logic                               rd_req,
    output logic [31:0]                        rd_addr,
    input  logic                               rd_rdy,
    output logic                               wr_req,
    output logic [31:0]                        wr_addr,
    output logic [dcache_pkg::line_bits-1:0]   wr_data,
    input  logic                               wr_rdy,
    input  logic                               ret_valid,
    input  logic                               ret_last,
    input  logic [31:0]                        ret_data,
    dcache_array_if.ctrl                       arr
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_next;

    // held request
    dcache_pkg::addr_t req_q;
    logic              op_q;
    logic [3:0]        wstrb_q;
    logic [31:0]       wdata_q;

    // miss buffer
    logic [dcache_pkg::way_bits-1:0]   mb_way;
    logic                              mb_valid;
    logic                              mb_dirty;
    logic [dcache_pkg::tag_bits-1:0]   mb_tag_old;
    logic [dcache_pkg::tag_bits-1:0]   mb_tag_new;
    logic [dcache_pkg::index_bits-1:0] mb_index;
    logic [dcache_pkg::line_bits-1:0]  mb_line;

    logic [dcache_pkg::way_bits-1:0]   way_cnt;    // pseudo-random victim choice
    logic [dcache_pkg::word_bits-1:0]  beat_cnt;
    logic                              hit_now;
    logic                              wb_pending;

    assign hit_now    = (state == dcache_pkg::state_lookup) && arr.hit;
    assign wb_pending = mb_valid && mb_dirty;

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::state_idle:
                if (req_valid) state_next = dcache_pkg::state_lookup;
            dcache_pkg::state_lookup:
                state_next = arr.hit ? dcache_pkg::state_idle : dcache_pkg::state_miss;
            dcache_pkg::state_miss:
                if (wb_pending) begin
                    state_next = dcache_pkg::state_writeback;
                end else if (rd_rdy) begin
                    state_next = dcache_pkg::state_refill;
                end
            dcache_pkg::state_writeback:
                if (wr_rdy) state_next = dcache_pkg::state_miss;   // then fetch the new line
            dcache_pkg::state_refill:
                if (ret_valid && ret_last) state_next = dcache_pkg::state_lookup;
            default:
                state_next = dcache_pkg::state_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= dcache_pkg::state_idle;
            way_cnt  <= '0;
            beat_cnt <= '0;
            mb_valid <= 1'b0;
            mb_dirty <= 1'b0;
        end else begin
            state   <= state_next;
            way_cnt <= way_cnt + 1'b1;   // steps every clock
            if (state != dcache_pkg::state_refill) begin
                beat_cnt <= '0;
            end else if (ret_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if ((state == dcache_pkg::state_lookup) && !arr.hit) begin
                mb_valid <= arr.victim_valid;
                mb_dirty <= arr.victim_dirty;
            end else if ((state == dcache_pkg::state_writeback) && wr_rdy) begin
                mb_dirty <= 1'b0;   // line is out
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == dcache_pkg::state_idle) && req_valid) begin
            req_q   <= req_addr;
            op_q    <= req_op;
            wstrb_q <= req_wstrb;
            wdata_q <= req_wdata;
        end
        if ((state == dcache_pkg::state_lookup) && !arr.hit) begin
            mb_way     <= way_cnt;
            mb_tag_old <= arr.victim_tag;
            mb_tag_new <= req_q.fields.tag;
            mb_index   <= req_q.fields.index;
            mb_line    <= arr.victim_line;
        end
    end

    assign req_ready  = (state == dcache_pkg::state_idle);
    assign resp_valid = hit_now;
    assign resp_rdata = arr.rdata_word;

    // memory side, held stable by the state until the handshake
    assign rd_req  = (state == dcache_pkg::state_miss) && !wb_pending;
    assign rd_addr = {req_q.raw[31:dcache_pkg::offset_bits], {dcache_pkg::offset_bits{1'b0}}};
    assign wr_req  = (state == dcache_pkg::state_writeback);
    assign wr_addr = {mb_tag_old, mb_index, {dcache_pkg::offset_bits{1'b0}}};
    assign wr_data = mb_line;

    assign arr.index      = req_q.fields.index;
    assign arr.req_tag    = req_q.fields.tag;
    assign arr.word       = req_q.fields.word;
    assign arr.victim_way = way_cnt;
    assign arr.store_en   = hit_now && op_q;   // store only commits on a hit
    assign arr.wstrb      = wstrb_q;
    assign arr.wdata      = wdata_q;

    assign arr.refill_en    = (state == dcache_pkg::state_refill) && ret_valid;
    assign arr.refill_way   = mb_way;
    assign arr.refill_index = mb_index;
    assign arr.refill_tag   = mb_tag_new;
    assign arr.refill_word  = beat_cnt;
    assign arr.refill_data  = ret_data;
    assign arr.refill_last  = ret_last;

endmodule

//--- dcache_data_array.sv
// word-organised line store; store data must sit in its own byte lanes under wstrb
`timescale 1ns/100ps

module dcache_data_array (
    input logic          clk,
    dcache_array_if.data arr
);

    logic [31:0] mem [dcache_pkg::num_ways][dcache_pkg::num_sets][dcache_pkg::words_per_line];

    // load data, valid only when the tag array reports a hit
    assign arr.rdata_word = mem[arr.hit_way][arr.index][arr.word];

    // whole victim line for the miss buffer
    always_comb begin
        for (int w = 0; w < dcache_pkg::words_per_line; w++) begin
            arr.victim_line[32*w +: 32] = mem[arr.victim_way][arr.index][w];
        end
    end

    always_ff @(posedge clk) begin
        if (arr.store_en) begin
            for (int b = 0; b < 4; b++) begin
                if (arr.wstrb[b]) begin
                    mem[arr.hit_way][arr.index][arr.word][8*b +: 8] <= arr.wdata[8*b +: 8];
                end
            end
        end
        if (arr.refill_en) begin
            // one word per returned beat
            mem[arr.refill_way][arr.refill_index][arr.refill_word] <= arr.refill_data;
        end
    end

endmodule

//--- dcache_pkg.sv
// geometry is fixed here (4 ways, 16 sets, 4 words per line); addresses are 32-bit byte addresses
package dcache_pkg;

    localparam int num_ways       = 4;
    localparam int num_sets       = 16;
    localparam int words_per_line = 4;

    localparam int way_bits    = $clog2(num_ways);
    localparam int index_bits  = $clog2(num_sets);
    localparam int word_bits   = $clog2(words_per_line);
    localparam int offset_bits = word_bits + 2;               // word offset plus byte offset
    localparam int tag_bits    = 32 - index_bits - offset_bits;
    localparam int line_bits   = words_per_line * 32;

    // cpu byte address, seen raw or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_bits-1:0]   tag;
            logic [index_bits-1:0] index;
            logic [word_bits-1:0]  word;
            logic [1:0]            byte_off;
        } fields;
    } addr_t;

    typedef enum logic [2:0] {
        state_idle      = 3'd0,
        state_lookup    = 3'd1,
        state_miss      = 3'd2,
        state_writeback = 3'd3,   // dirty victim line offered on the write channel
        state_refill    = 3'd4
    } ctrl_state_t;

endpackage

//--- dcache_tag_array.sv
// valid and dirty clear on reset, tags do not; a line turns valid only on its last refill beat
`timescale 1ns/100ps

module dcache_tag_array (
    input logic         clk,
    input logic         resetn,
    dcache_array_if.tags arr
);

    logic                            valid [dcache_pkg::num_ways][dcache_pkg::num_sets];
    logic                            dirty [dcache_pkg::num_ways][dcache_pkg::num_sets];
    logic [dcache_pkg::tag_bits-1:0] tags  [dcache_pkg::num_ways][dcache_pkg::num_sets];

    // compare all ways at the held index
    always_comb begin
        arr.hit     = 1'b0;
        arr.hit_way = '0;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (valid[w][arr.index] && (tags[w][arr.index] == arr.req_tag)) begin
                arr.hit     = 1'b1;
                arr.hit_way = w[dcache_pkg::way_bits-1:0];
            end
        end
    end

    // metadata of the line the counter points at
    assign arr.victim_valid = valid[arr.victim_way][arr.index];
    assign arr.victim_dirty = dirty[arr.victim_way][arr.index];
    assign arr.victim_tag   = tags[arr.victim_way][arr.index];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < dcache_pkg::num_ways; w++) begin
                for (int s = 0; s < dcache_pkg::num_sets; s++) begin
                    valid[w][s] <= 1'b0;
                    dirty[w][s] <= 1'b0;
                end
            end
        end else begin
            if (arr.store_en) begin
                dirty[arr.hit_way][arr.index] <= 1'b1;   // store hit
            end
            if (arr.refill_en && arr.refill_last) begin
                valid[arr.refill_way][arr.refill_index] <= 1'b1;
                dirty[arr.refill_way][arr.refill_index] <= 1'b0;   // fresh copy of memory
            end
        end
    end

    // tag written once the whole line is in
    always_ff @(posedge clk) begin
        if (arr.refill_en && arr.refill_last) begin
            tags[arr.refill_way][arr.refill_index] <= arr.refill_tag;
        end
    end

endmodule

//--- dcache_top.sv
// cpu side is valid/ready with a one-cycle response pulse that has no ready of its own
`timescale 1ns/100ps

module dcache_top (
    input  logic                             clk,
    input  logic                             resetn,
    // cpu side
    input  logic                             req_valid,
    input  logic                             req_op,     // 1 is a store
    input  logic [31:0]                      req_addr,
    input  logic [3:0]                       req_wstrb,
    input  logic [31:0]                      req_wdata,
    output logic                             req_ready,
    output logic                             resp_valid,
    output logic [31:0]                      resp_rdata,
    // memory side
    output logic                             rd_req,
    output logic [31:0]                      rd_addr,
    input  logic                             rd_rdy,
    output logic                             wr_req,
    output logic [31:0]                      wr_addr,
    output logic [dcache_pkg::line_bits-1:0] wr_data,
    input  logic                             wr_rdy,
    input  logic                             ret_valid,
    input  logic                             ret_last,
    input  logic [31:0]                      ret_data
);

    dcache_array_if arr ();

    dcache_ctrl i_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wstrb  (req_wstrb),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .arr        (arr.ctrl)
    );

    dcache_tag_array i_tag_array (
        .clk    (clk),
        .resetn (resetn),
        .arr    (arr.tags)
    );

    dcache_data_array i_data_array (
        .clk (clk),
        .arr (arr.data)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_dcache; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_dcache 2>&1)
status=$?
echo "$sim_out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

//--- tb_dcache.sv
// memory ready gaps are random from a fixed seed; only entries certain to hit check hit timing
`timescale 1ns/100ps

module tb_dcache;

    localparam int num_entries = 22;
    localparam int wait_limit  = 200;   // cycles per wait

    typedef struct packed {
        logic        op;      // 1 is a store
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic [31:0] rdata;   // expected load data
        logic        hit;     // must hit with no memory traffic
    } entry_t;

    logic                             clk;
    logic                             resetn;
    logic                             req_valid;
    logic                             req_op;
    logic [31:0]                      req_addr;
    logic [3:0]                       req_wstrb;
    logic [31:0]                      req_wdata;
    logic                             req_ready;
    logic                             resp_valid;
    logic [31:0]                      resp_rdata;
    logic                             rd_req;
    logic [31:0]                      rd_addr;
    logic                             rd_rdy;
    logic                             wr_req;
    logic [31:0]                      wr_addr;
    logic [dcache_pkg::line_bits-1:0] wr_data;
    logic                             wr_rdy;
    logic                             ret_valid;
    logic                             ret_last;
    logic [31:0]                      ret_data;

    int          errors;
    int          checks;
    int          seed;
    int          rd_count;
    int          wr_count;
    logic [31:0] mem_model [logic [29:0]];   // written-back words only
    bit          stored_lines [logic [31:0]];
    entry_t      stim [num_entries];

    dcache_top i_dcache_top (.*);

    always #50 clk = ~clk;

    // untouched memory reads as c0de over the low half of the word address
    function automatic logic [31:0] model_read(input logic [29:0] waddr);
        if (mem_model.exists(waddr)) begin
            return mem_model[waddr];
        end
        return {16'hc0de, waddr[15:0]};
    endfunction

    initial begin : memory_model
        logic [29:0]                      ret_base;
        int                               beats_left;
        int                               beat;
        logic                             rd_wait;
        logic                             wr_wait;
        logic [31:0]                      rd_addr_held;
        logic [31:0]                      wr_addr_held;
        logic [dcache_pkg::line_bits-1:0] wr_data_held;
        beats_left = 0;
        beat       = 0;
        rd_wait    = 1'b0;
        wr_wait    = 1'b0;
        forever begin
            @(negedge clk);   // everything settled mid-cycle
            if (resetn) begin
                if (rd_wait) begin
                    checks++;
                    assert (rd_req && rd_addr == rd_addr_held) else begin
                        $display("read request dropped or changed before its transfer at %0t", $time);
                        errors++;
                    end
                end
                if (wr_wait) begin
                    checks++;
                    assert (wr_req && wr_addr == wr_addr_held && wr_data == wr_data_held) else begin
                        $display("write request dropped or changed before its transfer at %0t", $time);
                        errors++;
                    end
                end
                rd_wait      = rd_req && !rd_rdy;
                wr_wait      = wr_req && !wr_rdy;
                rd_addr_held = rd_addr;
                wr_addr_held = wr_addr;
                wr_data_held = wr_data;
                if (wr_req && wr_rdy) begin
                    wr_count++;
                    checks++;
                    assert (wr_addr[3:0] == 4'h0 && stored_lines.exists(wr_addr)) else begin
                        $display("** Error: wr_addr = %h is not a line that was stored to", wr_addr);
                        errors++;
                    end
                    for (int w = 0; w < dcache_pkg::words_per_line; w++) begin
                        mem_model[wr_addr[31:2] + 30'(w)] = wr_data[32*w +: 32];
                    end
                end
                if (rd_req && rd_rdy) begin
                    rd_count++;
                    checks++;
                    assert (rd_addr[3:0] == 4'h0) else begin
                        $display("** Error: rd_addr = %h is not line-aligned", rd_addr);
                        errors++;
                    end
                    ret_base   = rd_addr[31:2];
                    beats_left = dcache_pkg::words_per_line;
                    beat       = 0;
                end
            end
            @(posedge clk);
            #1;
            ret_valid = beats_left > 0;
            ret_last  = beats_left == 1;
            ret_data  = ret_valid ? model_read(ret_base + 30'(beat)) : 32'h0;
            if (beats_left > 0) begin
                beats_left--;
                beat++;
            end
            rd_rdy = ($random(seed) & 3) == 0;   // ready one cycle in four on average
            wr_rdy = ($random(seed) & 3) == 0;
        end
    end

    initial begin
        entry_t e;
        int     cycles;
        int     rd_before;
        int     wr_before;
        logic   timed_out;
        seed      = 32'ha757;
        errors    = 0;
        checks    = 0;
        rd_count  = 0;
        wr_count  = 0;
        clk       = 1'b0;
        resetn    = 1'b0;
        req_valid = 1'b0;
        req_op    = 1'b0;
        req_addr  = 32'h0;
        req_wstrb = 4'h0;
        req_wdata = 32'h0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = 32'h0;
        timed_out = 1'b0;
        // all in set 3; tags 1 to 7 force evictions
        stim = '{
            '{1'b0, 32'h0000_0134, 4'h0, 32'h0000_0000, 32'hc0de_004d, 1'b0},
            '{1'b0, 32'h0000_0138, 4'h0, 32'h0000_0000, 32'hc0de_004e, 1'b1},
            '{1'b1, 32'h0000_0134, 4'h1, 32'h0000_00a5, 32'h0000_0000, 1'b1},
            '{1'b0, 32'h0000_0134, 4'h0, 32'h0000_0000, 32'hc0de_00a5, 1'b1},
            '{1'b1, 32'h0000_0138, 4'hc, 32'h1234_0000, 32'h0000_0000, 1'b1},
            '{1'b0, 32'h0000_0138, 4'h0, 32'h0000_0000, 32'h1234_004e, 1'b1},
            '{1'b1, 32'h0000_013c, 4'hf, 32'hdead_beef, 32'h0000_0000, 1'b1},
            '{1'b0, 32'h0000_013c, 4'h0, 32'h0000_0000, 32'hdead_beef, 1'b1},
            '{1'b1, 32'h0000_0234, 4'h2, 32'h0000_7700, 32'h0000_0000, 1'b0},
            '{1'b0, 32'h0000_0234, 4'h0, 32'h0000_0000, 32'hc0de_778d, 1'b1},
            '{1'b1, 32'h0000_0330, 4'h3, 32'h0000_beef, 32'h0000_0000, 1'b0},
            '{1'b0, 32'h0000_0330, 4'h0, 32'h0000_0000, 32'hc0de_beef, 1'b1},
            '{1'b0, 32'h0000_0430, 4'h0, 32'h0000_0000, 32'hc0de_010c, 1'b0},
            '{1'b0, 32'h0000_0530, 4'h0, 32'h0000_0000, 32'hc0de_014c, 1'b0},
            '{1'b0, 32'h0000_0630, 4'h0, 32'h0000_0000, 32'hc0de_018c, 1'b0},
            '{1'b0, 32'h0000_0730, 4'h0, 32'h0000_0000, 32'hc0de_01cc, 1'b0},
            '{1'b0, 32'h0000_0134, 4'h0, 32'h0000_0000, 32'hc0de_00a5, 1'b0},
            '{1'b0, 32'h0000_0138, 4'h0, 32'h0000_0000, 32'h1234_004e, 1'b1},
            '{1'b0, 32'h0000_013c, 4'h0, 32'h0000_0000, 32'hdead_beef, 1'b1},
            '{1'b0, 32'h0000_0234, 4'h0, 32'h0000_0000, 32'hc0de_778d, 1'b0},
            '{1'b0, 32'h0000_0330, 4'h0, 32'h0000_0000, 32'hc0de_beef, 1'b0},
            '{1'b0, 32'h0000_0334, 4'h0, 32'h0000_0000, 32'hc0de_00cd, 1'b1}
        };
        repeat (10) @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        checks++;
        assert (req_ready && !resp_valid && !rd_req && !wr_req) else begin
            $display("outputs are not idle after reset");
            errors++;
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < num_entries && !timed_out; i++) begin
            e         = stim[i];
            rd_before = rd_count;
            wr_before = wr_count;
            if (e.op) begin
                stored_lines[{e.addr[31:4], 4'h0}] = 1'b1;
            end
            req_valid = 1'b1;
            req_op    = e.op;
            req_addr  = e.addr;
            req_wstrb = e.strb;
            req_wdata = e.wdata;
            cycles    = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (!req_ready && cycles < wait_limit);
            if (!req_ready) begin
                $display("entry %0d was never accepted, req_ready stayed low", i);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);   // request transfers here
                #1 req_valid = 1'b0;
                cycles = 0;
                do begin
                    @(negedge clk);
                    cycles++;
                end while (!resp_valid && cycles < wait_limit);
                if (!resp_valid) begin
                    $display("entry %0d got no response within %0d cycles", i, wait_limit);
                    timed_out = 1'b1;
                end else begin
                    checks++;
                    assert (e.op || resp_rdata == e.rdata) else begin
                        $display("** Error: resp_rdata = %h, expected %h (entry %0d)",
                                 resp_rdata, e.rdata, i);
                        errors++;
                    end
                    checks++;
                    assert (!e.hit || (cycles == 1 && rd_count == rd_before
                                       && wr_count == wr_before)) else begin
                        $display("entry %0d should hit but took %0d cycles or went to memory",
                                 i, cycles);
                        errors++;
                    end
                    checks++;
                    assert (i != 0 || rd_count == rd_before + 1) else begin
                        $display("first load after reset did not fetch its line");
                        errors++;
                    end
                    @(negedge clk);   // cycle after the pulse
                    checks++;
                    assert (req_ready && !resp_valid) else begin
                        $display("entry %0d left resp_valid high or req_ready low", i);
                        errors++;
                    end
                    @(posedge clk);
                    #1;
                end
            end
        end
        checks++;
        assert (timed_out || wr_count > 0) else begin
            $display("no dirty line was ever written back");
            errors++;
        end
        if (timed_out) begin
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
dcache_pkg.sv
dcache_array_if.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv
